// ==== src/dcache_pkg.sv ====
package dcache_pkg;

  localparam int unsigned XLEN = 32;        // core and bus word width
  localparam int unsigned BE_W = XLEN / 8;  // byte enables per word

  ////////////////////////////////////////////////////////////////////////////
  // core and bus payloads
  ////////////////////////////////////////////////////////////////////////////

  // core request, held stable by the core until ack
  typedef struct packed {
    logic [XLEN-1:0] adr;
    logic            we;
    logic [XLEN-1:0] wdata;
    logic [BE_W-1:0] be;
    logic            cacheable;  // low means bypass the store
  } core_req_t;

  typedef enum logic [1:0] {
    NOP        = 2'd0,
    READ_LINE  = 2'd1,  // LINE_WORDS beats, word 0 first
    READ_WORD  = 2'd2,
    WRITE_WORD = 2'd3
  } bus_cmd_e;

  typedef struct packed {
    bus_cmd_e        cmd;
    logic [XLEN-1:0] adr;
    logic [XLEN-1:0] wdata;
    logic [BE_W-1:0] be;
  } bus_req_t;

  // one response beat
  typedef struct packed {
    logic [XLEN-1:0] rdata;
    logic            last;  // final beat of the request
    logic            err;
  } bus_rsp_t;

  // hit stage FSM
  typedef enum logic [2:0] {
    ARMED,
    FILL,
    NONCACHEABLE,
    WRITE_THROUGH,
    FLUSH,
    RECOVER
  } fsm_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // address split
  ////////////////////////////////////////////////////////////////////////////

  function automatic int unsigned offs_bits(int unsigned line_words);
    return 2 + $clog2(line_words);  // byte offset plus word in line
  endfunction

  function automatic int unsigned tag_bits(int unsigned sets, int unsigned line_words);
    return XLEN - offs_bits(line_words) - $clog2(sets);
  endfunction

  function automatic logic [XLEN-1:0] idx_of(logic [XLEN-1:0] adr, int unsigned sets,
                                             int unsigned line_words);
    return (adr >> offs_bits(line_words)) % sets;
  endfunction

  function automatic logic [XLEN-1:0] tag_of(logic [XLEN-1:0] adr, int unsigned sets,
                                             int unsigned line_words);
    return adr >> (offs_bits(line_words) + $clog2(sets));
  endfunction

  function automatic logic [XLEN-1:0] word_of(logic [XLEN-1:0] adr, int unsigned line_words);
    return (adr >> 2) % line_words;
  endfunction

  // byte lane merge, new bytes where be is set
  function automatic logic [XLEN-1:0] be_merge(logic [XLEN-1:0] old_w, logic [XLEN-1:0] new_w,
                                               logic [BE_W-1:0] be);
    logic [XLEN-1:0] res;
    for (int i = 0; i < BE_W; i++)
    begin
      res[i*8 +: 8] = be[i] ? new_w[i*8 +: 8] : old_w[i*8 +: 8];
    end
    return res;
  endfunction

endpackage

// ==== src/dcache_store.sv ====
`timescale 1ns/100ps

module dcache_store #(
  parameter  int unsigned SETS       = 16,
  parameter  int unsigned LINE_WORDS = 4,
  localparam int unsigned XLEN       = dcache_pkg::XLEN,
  localparam int unsigned BE_W       = dcache_pkg::BE_W,
  localparam int unsigned IDX_W      = $clog2(SETS),
  localparam int unsigned WORD_W     = $clog2(LINE_WORDS),
  localparam int unsigned TAG_W      = dcache_pkg::tag_bits(SETS, LINE_WORDS),
  localparam int unsigned LINE_W     = LINE_WORDS * XLEN
) (
  input  logic              clk_i,
  input  logic              rst_ni,

  // read port, combinational
  input  logic [IDX_W-1:0]  rd_idx_i,
  output logic              rd_valid_o,
  output logic [TAG_W-1:0]  rd_tag_o,
  output logic [LINE_W-1:0] rd_line_o,

  // word write, used by write hits and fill beats
  input  logic              wr_word_en_i,
  input  logic [IDX_W-1:0]  wr_idx_i,
  input  logic [WORD_W-1:0] wr_word_i,
  input  logic [XLEN-1:0]   wr_data_i,
  input  logic [BE_W-1:0]   wr_be_i,

  // line control
  input  logic              fill_en_i,   // last fill beat, line becomes valid
  input  logic [TAG_W-1:0]  fill_tag_i,
  input  logic              flush_en_i   // drop all lines
);

  logic [SETS-1:0]                  valid_q;
  logic [TAG_W-1:0]                 tag_mem  [SETS];
  logic [LINE_WORDS-1:0][XLEN-1:0]  data_mem [SETS];

  ////////////////////////////////////////////////////////////////////////////
  // valid bits
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
    if (!rst_ni)
      valid_q <= '0;
    else if (flush_en_i)
      valid_q <= '0;                 // whole cache in one cycle
    else if (fill_en_i)
      valid_q[wr_idx_i] <= 1'b1;

  ////////////////////////////////////////////////////////////////////////////
  // tag and data arrays
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i)
    if (fill_en_i)
      tag_mem[wr_idx_i] <= fill_tag_i;

  // byte merge on every word write, fill beats come with all lanes set
  always_ff @(posedge clk_i)
    if (wr_word_en_i)
    begin
      data_mem[wr_idx_i][wr_word_i] <= dcache_pkg::be_merge(data_mem[wr_idx_i][wr_word_i],
                                                            wr_data_i, wr_be_i);
    end

  assign rd_valid_o = valid_q[rd_idx_i];
  assign rd_tag_o   = tag_mem[rd_idx_i];
  assign rd_line_o  = data_mem[rd_idx_i];  // whole line, word picked in hit stage

endmodule

// ==== src/dcache_biu.sv ====
`timescale 1ns/100ps

module dcache_biu #(
  parameter  int unsigned LINE_WORDS  = 4,
  parameter  int unsigned MAX_CREDITS = 2,
  localparam int unsigned XLEN        = dcache_pkg::XLEN,
  localparam int unsigned BE_W        = dcache_pkg::BE_W,
  localparam int unsigned WORD_W      = $clog2(LINE_WORDS),
  localparam int unsigned CRED_W      = $clog2(MAX_CREDITS + 1)
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // from hit stage, held until done
  input  dcache_pkg::bus_cmd_e cmd_i,
  input  logic [XLEN-1:0]      adr_i,
  input  logic [XLEN-1:0]      wdata_i,
  input  logic [BE_W-1:0]      be_i,

  // to hit stage
  output logic                 done_o,        // with last beat
  output logic                 beat_valid_o,
  output logic [XLEN-1:0]      beat_data_o,
  output logic [WORD_W-1:0]    beat_word_o,
  output logic                 err_o,         // any beat of this request flagged

  // memory bus, credit based, no ready
  output logic                 bus_req_valid_o,
  output dcache_pkg::bus_req_t bus_req_o,
  input  logic                 credit_i,
  input  logic                 bus_rsp_valid_i,
  input  dcache_pkg::bus_rsp_t bus_rsp_i
);

  logic [CRED_W-1:0] credit_cnt_q;  // credits left
  logic              pending_q;     // request sent, beats outstanding
  logic [WORD_W-1:0] beat_cnt_q;
  logic              err_acc_q;
  logic              issue;

  // one request per command, only with a credit in hand
  assign issue = (cmd_i != dcache_pkg::NOP) && !pending_q && (credit_cnt_q != '0);

  assign bus_req_valid_o = issue;
  assign bus_req_o       = '{cmd: cmd_i, adr: adr_i, wdata: wdata_i, be: be_i};

  ////////////////////////////////////////////////////////////////////////////
  // credit counter
  ////////////////////////////////////////////////////////////////////////////

  // spend on issue, refill when memory hands one back
  always_ff @(posedge clk_i or negedge rst_ni)
    if (!rst_ni)
      credit_cnt_q <= CRED_W'(MAX_CREDITS);
    else
      credit_cnt_q <= credit_cnt_q - CRED_W'(issue) + CRED_W'(credit_i);

  ////////////////////////////////////////////////////////////////////////////
  // outstanding request and beats
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
    if (!rst_ni)
    begin
      pending_q  <= 1'b0;
      beat_cnt_q <= '0;
      err_acc_q  <= 1'b0;
    end
    else if (issue)
    begin
      pending_q  <= 1'b1;
      beat_cnt_q <= '0;                 // line beats start at word 0
      err_acc_q  <= 1'b0;
    end
    else if (beat_valid_o)
    begin
      if (bus_rsp_i.last)
        pending_q <= 1'b0;
      beat_cnt_q <= beat_cnt_q + 1'b1;
      err_acc_q  <= err_acc_q | bus_rsp_i.err;
    end

  assign beat_valid_o = bus_rsp_valid_i && pending_q;
  assign beat_data_o  = bus_rsp_i.rdata;
  assign beat_word_o  = beat_cnt_q;
  assign done_o       = beat_valid_o && bus_rsp_i.last;
  assign err_o        = err_acc_q | (beat_valid_o & bus_rsp_i.err);  // incl. current beat

endmodule

// ==== src/dcache_hit.sv ====
`timescale 1ns/100ps

module dcache_hit #(
  parameter  int unsigned SETS       = 16,
  parameter  int unsigned LINE_WORDS = 4,
  localparam int unsigned XLEN       = dcache_pkg::XLEN,
  localparam int unsigned BE_W       = dcache_pkg::BE_W,
  localparam int unsigned IDX_W      = $clog2(SETS),
  localparam int unsigned WORD_W     = $clog2(LINE_WORDS),
  localparam int unsigned TAG_W      = dcache_pkg::tag_bits(SETS, LINE_WORDS),
  localparam int unsigned LINE_W     = LINE_WORDS * XLEN
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  // core side
  input  logic                  req_i,
  input  dcache_pkg::core_req_t core_req_i,
  input  logic                  flush_req_i,
  output logic                  ack_o,
  output logic [XLEN-1:0]       q_o,
  output logic                  err_o,
  output logic                  stall_o,
  output logic                  flush_done_o,

  // store read
  output logic [IDX_W-1:0]      rd_idx_o,
  input  logic                  rd_valid_i,
  input  logic [TAG_W-1:0]      rd_tag_i,
  input  logic [LINE_W-1:0]     rd_line_i,

  // store write
  output logic                  wr_word_en_o,
  output logic [IDX_W-1:0]      wr_idx_o,
  output logic [WORD_W-1:0]     wr_word_o,
  output logic [XLEN-1:0]       wr_data_o,
  output logic [BE_W-1:0]       wr_be_o,
  output logic                  fill_en_o,
  output logic [TAG_W-1:0]      fill_tag_o,
  output logic                  flush_en_o,

  // bus interface unit
  output dcache_pkg::bus_cmd_e  biu_cmd_o,
  output logic [XLEN-1:0]       biu_adr_o,
  output logic [XLEN-1:0]       biu_wdata_o,
  output logic [BE_W-1:0]       biu_be_o,
  input  logic                  biu_done_i,
  input  logic                  biu_beat_valid_i,
  input  logic [XLEN-1:0]       biu_beat_data_i,
  input  logic [WORD_W-1:0]     biu_beat_word_i,
  input  logic                  biu_err_i
);

  localparam int unsigned OFFS_W = dcache_pkg::offs_bits(LINE_WORDS);

  dcache_pkg::fsm_state_e state_q;

  logic [IDX_W-1:0]  core_idx;
  logic [TAG_W-1:0]  core_tag;
  logic [WORD_W-1:0] core_word;
  logic              hit;
  logic              new_req;    // request seen, not yet acked
  logic              read_hit;
  logic              write_hit;
  logic [XLEN-1:0]   hit_word;

  ////////////////////////////////////////////////////////////////////////////
  // address split and tag compare
  ////////////////////////////////////////////////////////////////////////////

  assign core_idx  = IDX_W'(dcache_pkg::idx_of(core_req_i.adr, SETS, LINE_WORDS));
  assign core_tag  = TAG_W'(dcache_pkg::tag_of(core_req_i.adr, SETS, LINE_WORDS));
  assign core_word = WORD_W'(dcache_pkg::word_of(core_req_i.adr, LINE_WORDS));

  assign rd_idx_o = core_idx;
  assign hit      = rd_valid_i && (rd_tag_i == core_tag);
  assign hit_word = rd_line_i[core_word*XLEN +: XLEN];

  // ack_o high means core still holds the finished request this cycle
  assign new_req   = req_i && !ack_o;
  assign stall_o   = new_req;
  assign read_hit  = new_req && core_req_i.cacheable && !core_req_i.we && hit && !flush_req_i;
  assign write_hit = new_req && core_req_i.cacheable && core_req_i.we && hit && !flush_req_i;

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
    if (!rst_ni)
      state_q <= dcache_pkg::ARMED;
    else
      case (state_q)
        dcache_pkg::ARMED:
          if (flush_req_i)
            state_q <= dcache_pkg::FLUSH;
          else if (new_req && !core_req_i.cacheable)
            state_q <= dcache_pkg::NONCACHEABLE;
          else if (new_req && core_req_i.we)
            state_q <= dcache_pkg::WRITE_THROUGH;  // hit or miss, no allocate
          else if (new_req && !hit)
            state_q <= dcache_pkg::FILL;
        dcache_pkg::FILL:
          if (biu_done_i)
            state_q <= dcache_pkg::RECOVER;
        dcache_pkg::NONCACHEABLE,
        dcache_pkg::WRITE_THROUGH:
          if (biu_done_i)
            state_q <= dcache_pkg::ARMED;
        default:
          state_q <= dcache_pkg::ARMED;            // FLUSH, RECOVER are one cycle
      endcase

  // acknowledge, error and flush done
  always_ff @(posedge clk_i or negedge rst_ni)
    if (!rst_ni)
    begin
      ack_o        <= 1'b0;
      err_o        <= 1'b0;
      flush_done_o <= 1'b0;
    end
    else
    begin
      ack_o        <= 1'b0;
      err_o        <= 1'b0;
      flush_done_o <= (state_q == dcache_pkg::FLUSH);
      case (state_q)
        dcache_pkg::ARMED:
          ack_o <= read_hit;
        dcache_pkg::FILL:
          if (biu_done_i && biu_err_i)
          begin
            ack_o <= 1'b1;    // bad fill, line stays invalid
            err_o <= 1'b1;
          end
        dcache_pkg::NONCACHEABLE,
        dcache_pkg::WRITE_THROUGH:
        begin
          ack_o <= biu_done_i;
          err_o <= biu_done_i && biu_err_i;
        end
        default:
          ack_o <= 1'b0;
      endcase
    end

  // read data, only meaningful with ack_o
  always_ff @(posedge clk_i)
    if (state_q == dcache_pkg::ARMED)
      q_o <= hit_word;
    else if (biu_done_i)
      q_o <= biu_beat_data_i;  // bypass read, straight from bus

  ////////////////////////////////////////////////////////////////////////////
  // store write side
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    wr_idx_o     = core_idx;
    wr_word_en_o = write_hit;          // armed, core data under core be
    wr_word_o    = core_word;
    wr_data_o    = core_req_i.wdata;
    wr_be_o      = core_req_i.be;
    if (state_q == dcache_pkg::FILL)
    begin
      wr_word_en_o = biu_beat_valid_i; // every fill beat into the line
      wr_word_o    = biu_beat_word_i;
      wr_data_o    = biu_beat_data_i;
      wr_be_o      = '1;
    end
    else if (state_q != dcache_pkg::ARMED)
      wr_word_en_o = 1'b0;
  end

  assign fill_en_o  = (state_q == dcache_pkg::FILL) && biu_done_i && !biu_err_i;
  assign fill_tag_o = core_tag;
  assign flush_en_o = (state_q == dcache_pkg::FLUSH);

  ////////////////////////////////////////////////////////////////////////////
  // bus command, held by state until biu_done
  ////////////////////////////////////////////////////////////////////////////

  always_comb
    case (state_q)
      dcache_pkg::FILL:          biu_cmd_o = dcache_pkg::READ_LINE;
      dcache_pkg::WRITE_THROUGH: biu_cmd_o = dcache_pkg::WRITE_WORD;
      dcache_pkg::NONCACHEABLE:
        biu_cmd_o = core_req_i.we ? dcache_pkg::WRITE_WORD : dcache_pkg::READ_WORD;
      default:                   biu_cmd_o = dcache_pkg::NOP;
    endcase

  // line fills start at word 0 of the line
  assign biu_adr_o   = (state_q == dcache_pkg::FILL) ?
                       {core_req_i.adr[XLEN-1:OFFS_W], OFFS_W'(0)} : core_req_i.adr;
  assign biu_wdata_o = core_req_i.wdata;
  assign biu_be_o    = core_req_i.be;

endmodule

// ==== src/dcache_top.sv ====
`timescale 1ns/100ps

module dcache_top #(
  parameter int unsigned SETS        = 16,
  parameter int unsigned LINE_WORDS  = 4,
  parameter int unsigned MAX_CREDITS = 2
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,

  // core side
  input  logic                         req_i,
  input  dcache_pkg::core_req_t        core_req_i,
  input  logic                         flush_req_i,
  output logic                         ack_o,
  output logic [dcache_pkg::XLEN-1:0]  q_o,
  output logic                         err_o,
  output logic                         stall_o,
  output logic                         flush_done_o,

  // memory bus
  output logic                         bus_req_valid_o,
  output dcache_pkg::bus_req_t         bus_req_o,
  input  logic                         credit_i,
  input  logic                         bus_rsp_valid_i,
  input  dcache_pkg::bus_rsp_t         bus_rsp_i
);

  localparam int unsigned XLEN   = dcache_pkg::XLEN;
  localparam int unsigned BE_W   = dcache_pkg::BE_W;
  localparam int unsigned IDX_W  = $clog2(SETS);
  localparam int unsigned WORD_W = $clog2(LINE_WORDS);
  localparam int unsigned TAG_W  = dcache_pkg::tag_bits(SETS, LINE_WORDS);
  localparam int unsigned LINE_W = LINE_WORDS * XLEN;

  // hit stage to store
  logic [IDX_W-1:0]     rd_idx;
  logic                 rd_valid;
  logic [TAG_W-1:0]     rd_tag;
  logic [LINE_W-1:0]    rd_line;
  logic                 wr_word_en;
  logic [IDX_W-1:0]     wr_idx;
  logic [WORD_W-1:0]    wr_word;
  logic [XLEN-1:0]      wr_data;
  logic [BE_W-1:0]      wr_be;
  logic                 fill_en;
  logic [TAG_W-1:0]     fill_tag;
  logic                 flush_en;

  // hit stage to biu
  dcache_pkg::bus_cmd_e biu_cmd;
  logic [XLEN-1:0]      biu_adr;
  logic [XLEN-1:0]      biu_wdata;
  logic [BE_W-1:0]      biu_be;
  logic                 biu_done;
  logic                 biu_beat_valid;
  logic [XLEN-1:0]      biu_beat_data;
  logic [WORD_W-1:0]    biu_beat_word;
  logic                 biu_err;

  dcache_hit #(
    .SETS       (SETS),
    .LINE_WORDS (LINE_WORDS)
  ) u_hit (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .req_i            (req_i),
    .core_req_i       (core_req_i),
    .flush_req_i      (flush_req_i),
    .ack_o            (ack_o),
    .q_o              (q_o),
    .err_o            (err_o),
    .stall_o          (stall_o),
    .flush_done_o     (flush_done_o),
    .rd_idx_o         (rd_idx),
    .rd_valid_i       (rd_valid),
    .rd_tag_i         (rd_tag),
    .rd_line_i        (rd_line),
    .wr_word_en_o     (wr_word_en),
    .wr_idx_o         (wr_idx),
    .wr_word_o        (wr_word),
    .wr_data_o        (wr_data),
    .wr_be_o          (wr_be),
    .fill_en_o        (fill_en),
    .fill_tag_o       (fill_tag),
    .flush_en_o       (flush_en),
    .biu_cmd_o        (biu_cmd),
    .biu_adr_o        (biu_adr),
    .biu_wdata_o      (biu_wdata),
    .biu_be_o         (biu_be),
    .biu_done_i       (biu_done),
    .biu_beat_valid_i (biu_beat_valid),
    .biu_beat_data_i  (biu_beat_data),
    .biu_beat_word_i  (biu_beat_word),
    .biu_err_i        (biu_err)
  );

  dcache_store #(
    .SETS       (SETS),
    .LINE_WORDS (LINE_WORDS)
  ) u_store (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rd_idx_i     (rd_idx),
    .rd_valid_o   (rd_valid),
    .rd_tag_o     (rd_tag),
    .rd_line_o    (rd_line),
    .wr_word_en_i (wr_word_en),
    .wr_idx_i     (wr_idx),
    .wr_word_i    (wr_word),
    .wr_data_i    (wr_data),
    .wr_be_i      (wr_be),
    .fill_en_i    (fill_en),
    .fill_tag_i   (fill_tag),
    .flush_en_i   (flush_en)
  );

  dcache_biu #(
    .LINE_WORDS  (LINE_WORDS),
    .MAX_CREDITS (MAX_CREDITS)
  ) u_biu (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .cmd_i           (biu_cmd),
    .adr_i           (biu_adr),
    .wdata_i         (biu_wdata),
    .be_i            (biu_be),
    .done_o          (biu_done),
    .beat_valid_o    (biu_beat_valid),
    .beat_data_o     (biu_beat_data),
    .beat_word_o     (biu_beat_word),
    .err_o           (biu_err),
    .bus_req_valid_o (bus_req_valid_o),
    .bus_req_o       (bus_req_o),
    .credit_i        (credit_i),
    .bus_rsp_valid_i (bus_rsp_valid_i),
    .bus_rsp_i       (bus_rsp_i)
  );

endmodule

// ==== test/dcache_properties.sv ====
`timescale 1ns/100ps

module dcache_properties #(
  parameter int unsigned MAX_CREDITS = 2,
  parameter int unsigned CRED_W      = 2
) (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              bus_req_valid_i,
  input logic              credit_i,
  input logic [CRED_W-1:0] credit_cnt_i,
  input logic              done_i
);

  int unsigned fail_cnt = 0;  // failed assertions so far
  int          credits_q;     // credits as seen on the bus pins
  logic        req_open_q;    // bus request sent, done not seen yet

  // own count, spent by requests, refilled by memory
  always_ff @(posedge clk_i or negedge rst_ni)
    if (!rst_ni)
      credits_q <= int'(MAX_CREDITS);
    else
      credits_q <= credits_q - int'(bus_req_valid_i) + int'(credit_i);

  always_ff @(posedge clk_i or negedge rst_ni)
    if (!rst_ni)
      req_open_q <= 1'b0;
    else if (bus_req_valid_i)
      req_open_q <= 1'b1;
    else if (done_i)
      req_open_q <= 1'b0;

  ////////////////////////////////////////////////////////////////////////////
  // credit rules
  ////////////////////////////////////////////////////////////////////////////

  // no request without a credit in hand
  credit_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_req_valid_i |-> (credits_q > 0))
  else
  begin
    fail_cnt++;
    $error("bus request raised with zero credits");
  end

  credit_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_cnt_i <= CRED_W'(MAX_CREDITS))     // memory returned too many
  else
  begin
    fail_cnt++;
    $error("credit count above its maximum");
  end

  // done only closes an open request
  done_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |-> req_open_q)
  else
  begin
    fail_cnt++;
    $error("done without an outstanding bus request");
  end

endmodule

// ==== test/dcache_tb.sv ====
`timescale 1ns/100ps

module dcache_tb;

  localparam int unsigned SETS        = 16;
  localparam int unsigned LINE_WORDS  = 4;
  localparam int unsigned MAX_CREDITS = 2;
  localparam int unsigned MEM_WORDS   = 4096;      // 16 KiB behind the cache
  localparam int unsigned TIMEOUT     = 500;       // cycles per wait
  localparam int unsigned STARVE_DLY  = 60;        // credit hold while starving
  localparam logic [31:0] ERR_ADR     = 32'h3F0;   // this line answers with bus errors
  localparam logic [31:0] SEED        = 32'd73323;

  typedef enum logic [2:0] {OP_RD, OP_WR, OP_FLUSH, OP_POKE, OP_PEEK, OP_STARVE} op_e;

  // one stimulus row
  typedef struct packed {
    op_e         op;
    logic [31:0] adr;
    logic [31:0] data;       // write data, poke data, starve on/off
    logic [3:0]  be;
    logic        cacheable;
    logic [31:0] exp_q;
    logic        exp_err;
  } entry_t;

  logic                  clk_i = 1'b0;
  logic                  rst_ni;
  logic                  req_i;
  dcache_pkg::core_req_t core_req_i;
  logic                  flush_req_i;
  logic                  ack_o;
  logic [31:0]           q_o;
  logic                  err_o;
  logic                  stall_o;
  logic                  flush_done_o;
  logic                  bus_req_valid_o;
  dcache_pkg::bus_req_t  bus_req_o;
  logic                  credit_i        = 1'b0;
  logic                  bus_rsp_valid_i = 1'b0;
  dcache_pkg::bus_rsp_t  bus_rsp_i       = '0;

  // memory model state
  logic [31:0]           mem [MEM_WORDS];
  dcache_pkg::bus_req_t  req_q [$];          // accepted, not yet answered
  int                    cred_q [$];         // cycle at which each credit goes back
  dcache_pkg::bus_req_t  cur;
  logic                  busy   = 1'b0;
  int                    beat   = 0;
  int                    delay  = 0;
  int                    cyc    = 0;
  logic [31:0]           lfsr   = SEED;
  logic                  starve = 1'b0;

  string                 names [$];
  entry_t                stim_q [$];

  always #5 clk_i = ~clk_i;

  dcache_top #(
    .SETS        (SETS),
    .LINE_WORDS  (LINE_WORDS),
    .MAX_CREDITS (MAX_CREDITS)
  ) u_dcache_top (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .core_req_i      (core_req_i),
    .flush_req_i     (flush_req_i),
    .ack_o           (ack_o),
    .q_o             (q_o),
    .err_o           (err_o),
    .stall_o         (stall_o),
    .flush_done_o    (flush_done_o),
    .bus_req_valid_o (bus_req_valid_o),
    .bus_req_o       (bus_req_o),
    .credit_i        (credit_i),
    .bus_rsp_valid_i (bus_rsp_valid_i),
    .bus_rsp_i       (bus_rsp_i)
  );

  bind dcache_biu dcache_properties #(
    .MAX_CREDITS (MAX_CREDITS),
    .CRED_W      (CRED_W)
  ) u_props (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .bus_req_valid_i (bus_req_valid_o),
    .credit_i        (credit_i),
    .credit_cnt_i    (credit_cnt_q),
    .done_i          (done_o)
  );

  // galois lfsr, one step per random bit
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hB4BC_D35C) : (s >> 1);
  endfunction

  // memory fill, every address bit counts
  function automatic logic [31:0] pattern(logic [31:0] adr);
    return (adr * 32'h9E37_79B1) ^ {adr[15:0], adr[31:16]} ^ 32'h5A5A_0F0F;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // memory model, random answer delay, credit back after last beat
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i)
  begin : mem_model
    logic [11:0] widx;
    logic        last;
    logic [31:0] mask;
    bus_rsp_valid_i <= 1'b0;
    credit_i        <= 1'b0;
    cyc = cyc + 1;
    if (!rst_ni)
    begin
      for (int i = 0; i < MEM_WORDS; i++)
        mem[12'(i)] = pattern(32'(i) << 2);
    end
    else
    begin
      if (bus_req_valid_o)
        req_q.push_back(bus_req_o);
      if (!busy && req_q.size() != 0)
      begin
        cur   = req_q.pop_front();
        busy  = 1'b1;
        beat  = 0;
        delay = 0;
        for (int i = 0; i < 3; i++)            // 0 to 7 idle cycles
        begin
          lfsr  = lfsr_next(lfsr);
          delay = delay * 2 + int'(lfsr[0]);
        end
      end
      else if (busy && delay != 0)
        delay = delay - 1;
      else if (busy)
      begin
        widx = cur.adr[13:2] + 12'(beat);      // line address is word 0 aligned
        last = (cur.cmd != dcache_pkg::READ_LINE) || (beat == LINE_WORDS - 1);
        mask = {{8{cur.be[3]}}, {8{cur.be[2]}}, {8{cur.be[1]}}, {8{cur.be[0]}}};
        if (cur.cmd == dcache_pkg::WRITE_WORD)
          mem[widx] = (mem[widx] & ~mask) | (cur.wdata & mask);
        bus_rsp_i       <= '{rdata: mem[widx], last: last,
                             err: (cur.adr[31:4] == ERR_ADR[31:4])};
        bus_rsp_valid_i <= 1'b1;
        beat = beat + 1;
        if (last)
        begin
          busy = 1'b0;
          cred_q.push_back(cyc + (starve ? int'(STARVE_DLY) : 1));
        end
      end
      if (cred_q.size() != 0 && cred_q[0] <= cyc)
      begin
        void'(cred_q.pop_front());             // one credit per cycle
        credit_i <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks and waits
  ////////////////////////////////////////////////////////////////////////////

  task automatic fail_stop(string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1, "simulation stopped on first failure");
  endtask

  task automatic check(string name, logic [31:0] exp, logic [31:0] act);
    if (exp !== act)
      fail_stop($sformatf("error %s: expected %h, actual %h", name, exp, act));
  endtask

  // bus checker bound into the biu
  always @(posedge clk_i)
    if (u_dcache_top.u_biu.u_props.fail_cnt != 0)
      fail_stop("a bus protocol assertion failed");

  // flush_done_o when flush is set, else ack_o
  task automatic wait_done(string name, logic flush);
    int n;
    n = 0;
    do
    begin
      @(posedge clk_i);
      n++;
      if (n > TIMEOUT)
        fail_stop($sformatf("the cache never finished %s", name));
      if (!flush && !ack_o)
        check({name, " stall"}, 32'h1, 32'(stall_o));  // core held off until ack
    end
    while (!(flush ? flush_done_o : ack_o));
  endtask

  task automatic core_access(string name, entry_t e);
    @(posedge clk_i);
    req_i      <= 1'b1;
    core_req_i <= '{adr: e.adr, we: (e.op == OP_WR), wdata: e.data, be: e.be,
                    cacheable: e.cacheable};
    wait_done(name, 1'b0);
    req_i <= 1'b0;                             // ack seen, drop the request
    check({name, " err"}, 32'(e.exp_err), 32'(err_o));
    check({name, " stall"}, 32'h0, 32'(stall_o));
    if (e.op == OP_RD)
      check(name, e.exp_q, q_o);
  endtask

  task automatic cache_flush(string name);
    @(posedge clk_i);
    flush_req_i <= 1'b1;
    @(posedge clk_i);
    flush_req_i <= 1'b0;                       // one cycle pulse
    wait_done(name, 1'b1);
  endtask

  task automatic add(string name, op_e op, logic [31:0] adr, logic [31:0] data,
                     logic [3:0] be, logic cacheable, logic [31:0] exp_q, logic exp_err);
    names.push_back(name);
    stim_q.push_back('{op, adr, data, be, cacheable, exp_q, exp_err});
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////////////////////

  task automatic build_table();
    logic [31:0] p104;
    logic [31:0] p314;
    logic [31:0] m104;
    logic [31:0] m314;
    p104 = pattern(32'h104);
    p314 = pattern(32'h314);
    m104 = {p104[31:24], 8'hBB, p104[15:8], 8'hDD};   // lanes 0 and 2 written
    m314 = {16'h5566, p314[15:0]};                    // upper half written
    // miss then stale hit
    add("rd_miss",        OP_RD,     32'h100, 32'h0,         4'hF, 1'b1, pattern(32'h100), 1'b0);
    add("poke_100",       OP_POKE,   32'h100, 32'h1111_2222, 4'h0, 1'b0, 32'h0, 1'b0);
    add("rd_hit_stale",   OP_RD,     32'h100, 32'h0,         4'hF, 1'b1, pattern(32'h100), 1'b0);
    add("rd_hit_w3",      OP_RD,     32'h10C, 32'h0,         4'hF, 1'b1, pattern(32'h10C), 1'b0);
    // write-through, no allocate on a miss
    add("wr_hit",         OP_WR,     32'h104, 32'hAABB_CCDD, 4'h5, 1'b1, 32'h0, 1'b0);
    add("rd_merged",      OP_RD,     32'h104, 32'h0,         4'hF, 1'b1, m104, 1'b0);
    add("mem_merged",     OP_PEEK,   32'h104, 32'h0,         4'h0, 1'b0, m104, 1'b0);
    add("wr_miss",        OP_WR,     32'h228, 32'h0102_0304, 4'hF, 1'b1, 32'h0, 1'b0);
    add("rd_wr_miss",     OP_RD,     32'h228, 32'h0,         4'hF, 1'b1, 32'h0102_0304, 1'b0);
    // bypass sees memory, cached copy stays stale
    add("poke_108",       OP_POKE,   32'h108, 32'h3333_4444, 4'h0, 1'b0, 32'h0, 1'b0);
    add("nc_rd_108",      OP_RD,     32'h108, 32'h0,         4'hF, 1'b0, 32'h3333_4444, 1'b0);
    add("c_rd_108",       OP_RD,     32'h108, 32'h0,         4'hF, 1'b1, pattern(32'h108), 1'b0);
    // flush drops stale lines
    add("flush",          OP_FLUSH,  32'h0,   32'h0,         4'h0, 1'b0, 32'h0, 1'b0);
    add("rd_flushed",     OP_RD,     32'h100, 32'h0,         4'hF, 1'b1, 32'h1111_2222, 1'b0);
    add("rd_flushed_wt",  OP_RD,     32'h104, 32'h0,         4'hF, 1'b1, m104, 1'b0);
    add("rd_flushed_108", OP_RD,     32'h108, 32'h0,         4'hF, 1'b1, 32'h3333_4444, 1'b0);
    // credits held back by memory
    add("starve_on",      OP_STARVE, 32'h0,   32'h1,         4'h0, 1'b0, 32'h0, 1'b0);
    add("st_nc_wr",       OP_WR,     32'h300, 32'hCAFE_F00D, 4'hF, 1'b0, 32'h0, 1'b0);
    add("st_rd_miss",     OP_RD,     32'h310, 32'h0,         4'hF, 1'b1, pattern(32'h310), 1'b0);
    add("st_nc_rd",       OP_RD,     32'h300, 32'h0,         4'hF, 1'b0, 32'hCAFE_F00D, 1'b0);
    add("st_wr",          OP_WR,     32'h314, 32'h5566_7788, 4'hC, 1'b1, 32'h0, 1'b0);
    add("st_rd_hit",      OP_RD,     32'h314, 32'h0,         4'hF, 1'b1, m314, 1'b0);
    add("starve_off",     OP_STARVE, 32'h0,   32'h0,         4'h0, 1'b0, 32'h0, 1'b0);
    add("st_peek",        OP_PEEK,   32'h314, 32'h0,         4'h0, 1'b0, m314, 1'b0);
    // bus errors on the poisoned line
    add("nc_rd_err",      OP_RD,     32'h3F0, 32'h0,         4'hF, 1'b0, pattern(32'h3F0), 1'b1);
    add("nc_wr_err",      OP_WR,     32'h3F4, 32'h0,         4'hF, 1'b0, 32'h0, 1'b1);
    add("nc_rd_ok",       OP_RD,     32'h3E0, 32'h0,         4'hF, 1'b0, pattern(32'h3E0), 1'b0);
  endtask

  initial
  begin
    rst_ni      = 1'b0;
    req_i       = 1'b0;
    core_req_i  = '0;
    flush_req_i = 1'b0;
    build_table();
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    foreach (stim_q[i])
    begin
      case (stim_q[i].op)
        OP_RD,
        OP_WR:    core_access(names[i], stim_q[i]);
        OP_FLUSH: cache_flush(names[i]);
        OP_POKE:  mem[stim_q[i].adr[13:2]] = stim_q[i].data;   // behind the cache
        OP_PEEK:  check(names[i], stim_q[i].exp_q, mem[stim_q[i].adr[13:2]]);
        default:  starve = stim_q[i].data[0];
      endcase
    end
    if (u_dcache_top.u_biu.u_props.fail_cnt != 0)
      fail_stop("a bus protocol assertion failed");
    else
    begin
      $display("No errors");
      $finish;
    end
  end

endmodule

// ==== dcache.f ====
src/dcache_pkg.sv
src/dcache_store.sv
src/dcache_biu.sv
src/dcache_hit.sv
src/dcache_top.sv
test/dcache_properties.sv
test/dcache_tb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := dcache_tb
FILELIST := dcache.f
BUILD    := obj_dir

SRCS := $(shell cat $(FILELIST))
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

# exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD)
